//--- Makefile
# Verilator build and run for the flow control issue stage

VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := fcu_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# pass or fail comes from the log, not the exit status of the run
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/fcu_consts.svh
// fcu sizing constants shared by the issue stage and its package
`ifndef FCU_CONSTS_SVH
`define FCU_CONSTS_SVH

// ==============================
// queue and sequence sizing
// ==============================

// number of instruction queue slots
`define IQ_ENTRIES 8

// program order stamp width, wraps far past the queue depth
`define SN_W 8

// ==============================
// datapath and timing
// ==============================

// operand and pc width
`define DATA_W 32

// busy cycles the fcu spends on each op
`define FCU_LATENCY 2

`endif

//--- logic/fcu_exec.sv
// multi-cycle flow control unit resolving branch condition, target and mispredict
`default_nettype none

`include "fcu_consts.svh"

module fcu_exec (
	input  wire                           clk,
	input  wire                           rst,
	input  wire [`IQ_ENTRIES-1:0]         issue,
	input  wire fcu_pkg::fcu_op_e         sel_op,
	input  wire [`DATA_W-1:0]             sel_a,
	input  wire [`DATA_W-1:0]             sel_b,
	input  wire [`DATA_W-1:0]             sel_pc,
	input  wire [`DATA_W-1:0]             sel_target,
	input  wire                           sel_pred,
	input  wire fcu_pkg::seqnum_t         sel_sn,
	output logic                          fcu_idle,
	output logic                          done_pulse,
	output logic                          taken,
	output logic                          miss,
	output fcu_pkg::qid_t                 done_qid,
	output fcu_pkg::seqnum_t              done_sn,
	output logic [`DATA_W-1:0]            next_pc
);
	import fcu_pkg::*;

	localparam int CNT_W = $clog2(`FCU_LATENCY + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`FCU_LATENCY - 1);

	fcu_state_e         state;
	logic [CNT_W-1:0]   cnt;

	// latched op
	fcu_op_e            op_q;
	logic [`DATA_W-1:0] a_q;
	logic [`DATA_W-1:0] b_q;
	logic [`DATA_W-1:0] pc_q;
	logic [`DATA_W-1:0] tgt_q;
	logic               pred_q;
	seqnum_t            sn_q;
	qid_t               qid_q;
	logic               cond;
	logic               start;

	// an issue is only ever presented while idle
	assign start = (state == FCU_IDLE) && (|issue);

	// ==============================
	// sequencing
	// ==============================

	// idle -> busy for FCU_LATENCY cycles -> one done cycle -> idle
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FCU_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				FCU_IDLE: begin
					if (start) begin
						state <= FCU_BUSY;
						cnt   <= '0;
					end
				end
				FCU_BUSY: begin
					if (cnt == CNT_LAST)
						state <= FCU_DONE;
					else
						cnt <= cnt + 1'b1;
				end
				default: state <= FCU_IDLE;
			endcase
		end
	end

	// operands and tags of the op being resolved
	always_ff @(posedge clk) begin
		if (start) begin
			op_q   <= sel_op;
			a_q    <= sel_a;
			b_q    <= sel_b;
			pc_q   <= sel_pc;
			tgt_q  <= sel_target;
			pred_q <= sel_pred;
			sn_q   <= sel_sn;
			qid_q  <= onehot_to_qid(issue);
		end
	end

	// ==============================
	// resolution
	// ==============================

	always_comb begin
		case (op_q)
			OP_BEQ:  cond = (a_q == b_q);
			OP_BNE:  cond = (a_q != b_q);
			// signed compare
			OP_BLT:  cond = ($signed(a_q) < $signed(b_q));
			OP_JMP:  cond = 1'b1;
			default: cond = 1'b0;
		endcase
	end

	assign taken      = cond;
	assign miss       = cond ^ pred_q;
	assign next_pc    = cond ? tgt_q : pc_q + `DATA_W'(4);
	assign done_qid   = qid_q;
	assign done_sn    = sn_q;
	assign fcu_idle   = (state == FCU_IDLE);
	assign done_pulse = (state == FCU_DONE);

	// selector must hold off until the fcu is back in idle
	a_issue_when_idle: assert property (@(posedge clk) disable iff (rst)
		(|issue) |-> (state == FCU_IDLE))
		else $error("fcu_exec: issue %b seen in state %s", issue, state.name());

endmodule

`default_nettype wire

//--- logic/fcu_iq.sv
// instruction queue holding dispatched flow control ops until they retire
`default_nettype none

`include "fcu_consts.svh"

module fcu_iq (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            disp_valid,
	input  wire fcu_pkg::fcu_op_e          disp_op,
	input  wire [`DATA_W-1:0]              disp_a,
	input  wire [`DATA_W-1:0]              disp_b,
	input  wire [`DATA_W-1:0]              disp_pc,
	input  wire [`DATA_W-1:0]              disp_target,
	input  wire                            disp_pred,
	input  wire                            disp_sync,
	input  wire [`IQ_ENTRIES-1:0]          issue,
	input  wire                            retire_pulse,
	input  wire fcu_pkg::qid_t             retire_qid,
	input  wire                            flush_pulse,
	input  wire fcu_pkg::seqnum_t          flush_sn,
	output logic                           disp_ready,
	output logic [`IQ_ENTRIES-1:0]         iq_valid,
	output logic [`IQ_ENTRIES-1:0]         iq_issued,
	output logic [`IQ_ENTRIES-1:0]         iq_prior_sync,
	output fcu_pkg::fcu_op_e               sel_op,
	output logic [`DATA_W-1:0]             sel_a,
	output logic [`DATA_W-1:0]             sel_b,
	output logic [`DATA_W-1:0]             sel_pc,
	output logic [`DATA_W-1:0]             sel_target,
	output logic                           sel_pred,
	output fcu_pkg::seqnum_t               sel_sn
);
	import fcu_pkg::*;

	// per slot payload
	fcu_op_e                op_q  [`IQ_ENTRIES];
	logic [`DATA_W-1:0]     a_q   [`IQ_ENTRIES];
	logic [`DATA_W-1:0]     b_q   [`IQ_ENTRIES];
	logic [`DATA_W-1:0]     pc_q  [`IQ_ENTRIES];
	logic [`DATA_W-1:0]     tgt_q [`IQ_ENTRIES];
	seqnum_t                sn_q  [`IQ_ENTRIES];
	logic [`IQ_ENTRIES-1:0] pred_q;
	logic [`IQ_ENTRIES-1:0] sync_q;

	// per slot control
	logic [`IQ_ENTRIES-1:0] valid_q;
	logic [`IQ_ENTRIES-1:0] issued_q;
	seqnum_t                next_sn;
	qid_t                   free_idx;
	qid_t                   sel_idx;
	logic                   disp_fire;

	// ==============================
	// allocation
	// ==============================

	// downward scan so the lowest free slot wins
	always_comb begin
		free_idx = '0;
		for (int i = `IQ_ENTRIES - 1; i >= 0; i--) begin
			if (!valid_q[i])
				free_idx = qid_t'(i);
		end
	end

	assign disp_ready = ~&valid_q;
	assign disp_fire  = disp_valid & disp_ready;

	// a slot waits while any older valid sync entry is still queued
	always_comb begin
		for (int n = 0; n < `IQ_ENTRIES; n++) begin
			iq_prior_sync[n] = 1'b0;
			for (int m = 0; m < `IQ_ENTRIES; m++) begin
				if (valid_q[m] && sync_q[m] && sn_older(sn_q[m], sn_q[n]))
					iq_prior_sync[n] = 1'b1;
			end
		end
	end

	assign iq_valid  = valid_q;
	assign iq_issued = issued_q;

	// fields of the slot named by the one-hot issue vector
	assign sel_idx    = onehot_to_qid(issue);
	assign sel_op     = op_q[sel_idx];
	assign sel_a      = a_q[sel_idx];
	assign sel_b      = b_q[sel_idx];
	assign sel_pc     = pc_q[sel_idx];
	assign sel_target = tgt_q[sel_idx];
	assign sel_pred   = pred_q[sel_idx];
	assign sel_sn     = sn_q[sel_idx];

	// ==============================
	// slot state
	// ==============================

	// issue marks on the same edge the fcu takes the op
	// a new write overrides a flush landing on the same edge
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q  <= '0;
			issued_q <= '0;
			next_sn  <= '0;
		end else begin
			for (int i = 0; i < `IQ_ENTRIES; i++) begin
				if (issue[i])
					issued_q[i] <= 1'b1;
				if (flush_pulse && valid_q[i] && sn_older(flush_sn, sn_q[i]))
					valid_q[i] <= 1'b0;
			end
			if (retire_pulse)
				valid_q[retire_qid] <= 1'b0;
			if (disp_fire) begin
				valid_q[free_idx]  <= 1'b1;
				issued_q[free_idx] <= 1'b0;
				next_sn            <= next_sn + 1'b1;
			end
		end
	end

	// payload capture
	always_ff @(posedge clk) begin
		if (disp_fire) begin
			op_q[free_idx]   <= disp_op;
			a_q[free_idx]    <= disp_a;
			b_q[free_idx]    <= disp_b;
			pc_q[free_idx]   <= disp_pc;
			tgt_q[free_idx]  <= disp_target;
			sn_q[free_idx]   <= next_sn;
			pred_q[free_idx] <= disp_pred;
			sync_q[free_idx] <= disp_sync;
		end
	end

	// the selector may only name a queued, not yet issued slot
	a_issue_waiting: assert property (@(posedge clk) disable iff (rst)
		(issue & ~(valid_q & ~issued_q)) == '0)
		else $error("fcu_iq: issue %b names a slot that is not waiting", issue);

endmodule

`default_nettype wire

//--- logic/fcu_issue_select.sv
// issue selector that picks the lowest ready queue slot when the fcu is free
`default_nettype none

`include "fcu_consts.svh"

module fcu_issue_select (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    ce,
	input  wire                    fcu_idle,
	input  wire                    flush_pulse,
	input  wire [`IQ_ENTRIES-1:0]  iq_valid,
	input  wire [`IQ_ENTRIES-1:0]  iq_issued,
	input  wire [`IQ_ENTRIES-1:0]  iq_prior_sync,
	output logic [`IQ_ENTRIES-1:0] issue
);

	// slots that could go if the fcu were free
	logic [`IQ_ENTRIES-1:0] ready_vec;
	// next cycle issue pick
	logic [`IQ_ENTRIES-1:0] issuep;
	// global permission to pick this cycle
	logic                   pick_ok;

	// ==============================
	// eligibility
	// ==============================

	// queued, not yet sent and not held behind an older sync op
	assign ready_vec = iq_valid & ~iq_issued & ~iq_prior_sync;

	// the fcu has not latched the previous pick while issue is still up
	// so our own register blocks a second pick
	// no pick in a flush cycle, younger slots are about to vanish
	assign pick_ok = ce & fcu_idle & ~flush_pulse & ~|issue;

	// ascending scan, first ready slot wins
	always_comb begin
		issuep = '0;
		if (pick_ok) begin
			for (int n = 0; n < `IQ_ENTRIES; n++) begin
				if (ready_vec[n] && issuep == '0)
					issuep[n] = 1'b1;
			end
		end
	end

	// ==============================
	// issue register
	// ==============================

	// ce is folded into pick_ok so issue drops after one cycle
	always_ff @(posedge clk) begin
		if (rst)
			issue <= '0;
		else
			issue <= issuep;
	end

	a_issue_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(issue))
		else $error("fcu_issue_select: issue %b is not one-hot", issue);

endmodule

`default_nettype wire

//--- logic/fcu_outcome.sv
// outcome reporter that retires resolved ops and raises redirect and flush on a miss
`default_nettype none

`include "fcu_consts.svh"

module fcu_outcome (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    done_pulse,
	input  wire                    taken,
	input  wire                    miss,
	input  wire fcu_pkg::qid_t     done_qid,
	input  wire fcu_pkg::seqnum_t  done_sn,
	input  wire [`DATA_W-1:0]      next_pc,
	output logic                   retire_pulse,
	output fcu_pkg::qid_t          retire_qid,
	output fcu_pkg::seqnum_t       retire_sn,
	output logic                   retire_taken,
	output logic                   redirect_valid,
	output logic [`DATA_W-1:0]     redirect_pc,
	output logic                   flush_pulse,
	output fcu_pkg::seqnum_t       flush_sn,
	output logic [15:0]            miss_count
);

	// ==============================
	// strobes
	// ==============================

	// all strobes trail done_pulse by one cycle
	// redirect and flush fire together, only on a mispredict
	always_ff @(posedge clk) begin
		if (rst) begin
			retire_pulse   <= 1'b0;
			redirect_valid <= 1'b0;
			flush_pulse    <= 1'b0;
			miss_count     <= '0;
		end else begin
			retire_pulse   <= done_pulse;
			redirect_valid <= done_pulse & miss;
			flush_pulse    <= done_pulse & miss;
			// saturates at all ones
			if (done_pulse && miss && miss_count != '1)
				miss_count <= miss_count + 1'b1;
		end
	end

	// ==============================
	// outcome fields
	// ==============================

	// held until the next resolved op
	always_ff @(posedge clk) begin
		if (done_pulse) begin
			retire_qid   <= done_qid;
			retire_sn    <= done_sn;
			retire_taken <= taken;
			redirect_pc  <= next_pc;
			// queue drops everything younger than this op
			flush_sn     <= done_sn;
		end
	end

endmodule

`default_nettype wire

//--- logic/fcu_pkg.sv
// fcu package with queue index, sequence number, opcode and fcu state types
`default_nettype none

`include "fcu_consts.svh"

package fcu_pkg;

	// queue slot index
	typedef logic [$clog2(`IQ_ENTRIES)-1:0] qid_t;

	// program order stamp
	typedef logic [`SN_W-1:0] seqnum_t;

	// flow control opcodes
	typedef enum logic [1:0] {
		OP_BEQ = 2'd0,
		OP_BNE = 2'd1,
		OP_BLT = 2'd2,
		OP_JMP = 2'd3
	} fcu_op_e;

	// fcu sequencing
	typedef enum logic [1:0] {
		FCU_IDLE = 2'd0,
		FCU_BUSY = 2'd1,
		FCU_DONE = 2'd2
	} fcu_state_e;

	// true when a is older than b, safe across counter wrap
	function automatic logic sn_older(input seqnum_t a, input seqnum_t b);
		seqnum_t diff;
		diff = b - a;
		return (diff != '0) && !diff[`SN_W-1];
	endfunction

	// one-hot slot vector to index, zero when nothing is set
	function automatic qid_t onehot_to_qid(input logic [`IQ_ENTRIES-1:0] v);
		qid_t idx;
		idx = '0;
		for (int i = 0; i < `IQ_ENTRIES; i++) begin
			if (v[i])
				idx = idx | qid_t'(i);
		end
		return idx;
	endfunction

endpackage

`default_nettype wire

//--- logic/fcu_top.sv
// flow control issue stage top with queue, selector, fcu and outcome reporter
`default_nettype none

`include "fcu_consts.svh"

module fcu_top (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    ce,
	input  wire                    disp_valid,
	input  wire fcu_pkg::fcu_op_e  disp_op,
	input  wire [`DATA_W-1:0]      disp_a,
	input  wire [`DATA_W-1:0]      disp_b,
	input  wire [`DATA_W-1:0]      disp_pc,
	input  wire [`DATA_W-1:0]      disp_target,
	input  wire                    disp_pred,
	input  wire                    disp_sync,
	output logic                   disp_ready,
	output logic                   retire_pulse,
	output fcu_pkg::qid_t          retire_qid,
	output fcu_pkg::seqnum_t       retire_sn,
	output logic                   retire_taken,
	output logic                   redirect_valid,
	output logic [`DATA_W-1:0]     redirect_pc,
	output logic [15:0]            miss_count
);
	import fcu_pkg::*;

	// queue <-> selector
	logic [`IQ_ENTRIES-1:0] iq_valid;
	logic [`IQ_ENTRIES-1:0] iq_issued;
	logic [`IQ_ENTRIES-1:0] iq_prior_sync;
	logic [`IQ_ENTRIES-1:0] issue;

	// queue -> fcu
	fcu_op_e                sel_op;
	logic [`DATA_W-1:0]     sel_a;
	logic [`DATA_W-1:0]     sel_b;
	logic [`DATA_W-1:0]     sel_pc;
	logic [`DATA_W-1:0]     sel_target;
	logic                   sel_pred;
	seqnum_t                sel_sn;

	// fcu -> reporter
	logic                   fcu_idle;
	logic                   done_pulse;
	logic                   taken;
	logic                   miss;
	qid_t                   done_qid;
	seqnum_t                done_sn;
	logic [`DATA_W-1:0]     next_pc;

	// reporter -> queue
	logic                   flush_pulse;
	seqnum_t                flush_sn;

	fcu_iq u_iq (
		.clk          (clk),
		.rst          (rst),
		.disp_valid   (disp_valid),
		.disp_op      (disp_op),
		.disp_a       (disp_a),
		.disp_b       (disp_b),
		.disp_pc      (disp_pc),
		.disp_target  (disp_target),
		.disp_pred    (disp_pred),
		.disp_sync    (disp_sync),
		.issue        (issue),
		.retire_pulse (retire_pulse),
		.retire_qid   (retire_qid),
		.flush_pulse  (flush_pulse),
		.flush_sn     (flush_sn),
		.disp_ready   (disp_ready),
		.iq_valid     (iq_valid),
		.iq_issued    (iq_issued),
		.iq_prior_sync(iq_prior_sync),
		.sel_op       (sel_op),
		.sel_a        (sel_a),
		.sel_b        (sel_b),
		.sel_pc       (sel_pc),
		.sel_target   (sel_target),
		.sel_pred     (sel_pred),
		.sel_sn       (sel_sn)
	);

	fcu_issue_select u_sel (
		.clk          (clk),
		.rst          (rst),
		.ce           (ce),
		.fcu_idle     (fcu_idle),
		.flush_pulse  (flush_pulse),
		.iq_valid     (iq_valid),
		.iq_issued    (iq_issued),
		.iq_prior_sync(iq_prior_sync),
		.issue        (issue)
	);

	fcu_exec u_exec (
		.clk        (clk),
		.rst        (rst),
		.issue      (issue),
		.sel_op     (sel_op),
		.sel_a      (sel_a),
		.sel_b      (sel_b),
		.sel_pc     (sel_pc),
		.sel_target (sel_target),
		.sel_pred   (sel_pred),
		.sel_sn     (sel_sn),
		.fcu_idle   (fcu_idle),
		.done_pulse (done_pulse),
		.taken      (taken),
		.miss       (miss),
		.done_qid   (done_qid),
		.done_sn    (done_sn),
		.next_pc    (next_pc)
	);

	fcu_outcome u_out (
		.clk           (clk),
		.rst           (rst),
		.done_pulse    (done_pulse),
		.taken         (taken),
		.miss          (miss),
		.done_qid      (done_qid),
		.done_sn       (done_sn),
		.next_pc       (next_pc),
		.retire_pulse  (retire_pulse),
		.retire_qid    (retire_qid),
		.retire_sn     (retire_sn),
		.retire_taken  (retire_taken),
		.redirect_valid(redirect_valid),
		.redirect_pc   (redirect_pc),
		.flush_pulse   (flush_pulse),
		.flush_sn      (flush_sn),
		.miss_count    (miss_count)
	);

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/fcu_pkg.sv
logic/fcu_iq.sv
logic/fcu_issue_select.sv
logic/fcu_exec.sv
logic/fcu_outcome.sv
logic/fcu_top.sv
verif/fcu_tb.sv

//--- verif/fcu_tb.sv
// testbench for the flow control issue stage, checks retires against a reference model
`default_nettype none

`include "fcu_consts.svh"

module fcu_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import fcu_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int N_RAND       = 8;
	// random, mispredict, flush, sync and back-pressure dispatches
	localparam int N_DISP       = N_RAND + 2 + 5 + 4 + 9;
	localparam int WATCHDOG_CYC = N_DISP * 40 + 16;

	// one expected retire
	typedef struct packed {
		seqnum_t            sn;
		qid_t               qid;
		logic               taken;
		logic               miss;
		logic [`DATA_W-1:0] next_pc;
	} exp_rec_t;

	logic               clk = 1'b0;
	logic               rst;
	logic               ce;
	logic               disp_valid;
	fcu_op_e            disp_op;
	logic [`DATA_W-1:0] disp_a;
	logic [`DATA_W-1:0] disp_b;
	logic [`DATA_W-1:0] disp_pc;
	logic [`DATA_W-1:0] disp_target;
	logic               disp_pred;
	logic               disp_sync;
	logic               disp_ready;
	logic               retire_pulse;
	qid_t               retire_qid;
	seqnum_t            retire_sn;
	logic               retire_taken;
	logic               redirect_valid;
	logic [`DATA_W-1:0] redirect_pc;
	logic [15:0]        miss_count;

	// reference model state
	exp_rec_t exp_q[$];
	seqnum_t  sn_ctr = '0;
	int       disp_total = 0;
	int       retire_total = 0;
	int       exp_misses = 0;
	logic     in_order = 1'b0;
	logic     reset_chk = 1'b1;
	logic     ret_seen = 1'b0;
	seqnum_t  ret_sn_seen;

	// slot model, each write takes the lowest free slot
	logic [`IQ_ENTRIES-1:0] slot_busy = '0;
	seqnum_t                slot_sn [`IQ_ENTRIES];
	logic                   claim_pend = 1'b0;
	qid_t                   claim_qid;
	seqnum_t                claim_sn;

	integer   seed = 32'h7727;
	int       errors = 0;
	int       err_mark = 0;
	int       tests_run = 0;
	int       tests_failed = 0;
	string    test_name = "reset_state";

	fcu_top dut_i (
		.clk           (clk),
		.rst           (rst),
		.ce            (ce),
		.disp_valid    (disp_valid),
		.disp_op       (disp_op),
		.disp_a        (disp_a),
		.disp_b        (disp_b),
		.disp_pc       (disp_pc),
		.disp_target   (disp_target),
		.disp_pred     (disp_pred),
		.disp_sync     (disp_sync),
		.disp_ready    (disp_ready),
		.retire_pulse  (retire_pulse),
		.retire_qid    (retire_qid),
		.retire_sn     (retire_sn),
		.retire_taken  (retire_taken),
		.redirect_valid(redirect_valid),
		.redirect_pc   (redirect_pc),
		.miss_count    (miss_count)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ==============================
	// reference model
	// ==============================

	// branch outcome straight from the opcode rules
	function automatic logic ref_taken(input fcu_op_e op, input logic [`DATA_W-1:0] a,
			input logic [`DATA_W-1:0] b);
		case (op)
			OP_BEQ:  return a == b;
			OP_BNE:  return a != b;
			OP_BLT:  return $signed(a) < $signed(b);
			default: return 1'b1;
		endcase
	endfunction

	// position of a pending record, -1 when absent
	function automatic int find_idx(input seqnum_t sn);
		for (int i = 0; i < exp_q.size(); i++) begin
			if (exp_q[i].sn == sn)
				return i;
		end
		return -1;
	endfunction

	function automatic logic sn_expected(input seqnum_t sn);
		int idx;
		idx = find_idx(sn);
		return (idx >= 0) && (!in_order || idx == 0);
	endfunction

	function automatic seqnum_t oldest_sn();
		return (exp_q.size() != 0) ? exp_q[0].sn : '0;
	endfunction

	function automatic logic exp_taken(input seqnum_t sn);
		int idx;
		idx = find_idx(sn);
		return (idx < 0) ? 1'b0 : exp_q[idx].taken;
	endfunction

	function automatic logic exp_miss(input seqnum_t sn);
		int idx;
		idx = find_idx(sn);
		return (idx < 0) ? 1'b0 : exp_q[idx].miss;
	endfunction

	function automatic logic [`DATA_W-1:0] exp_next_pc(input seqnum_t sn);
		int idx;
		idx = find_idx(sn);
		return (idx < 0) ? '0 : exp_q[idx].next_pc;
	endfunction

	function automatic qid_t exp_qid(input seqnum_t sn);
		int idx;
		idx = find_idx(sn);
		return (idx < 0) ? '0 : exp_q[idx].qid;
	endfunction

	// first empty slot counting up from zero
	function automatic qid_t lowest_free_slot();
		for (int i = 0; i < `IQ_ENTRIES; i++) begin
			if (!slot_busy[i])
				return qid_t'(i);
		end
		return '0;
	endfunction

	// outputs are stable mid cycle, the model only moves on the rising edge
	always @(negedge clk) begin
		ret_seen    <= retire_pulse && !rst;
		ret_sn_seen <= retire_sn;
	end

	always @(posedge clk) begin : model_retire
		int idx;
		if (ret_seen) begin
			idx = find_idx(ret_sn_seen);
			if (idx >= 0) begin
				slot_busy[exp_q[idx].qid] = 1'b0;
				if (exp_q[idx].miss) begin
					exp_misses++;
					// a miss empties every younger slot on the same edge
					for (int i = 0; i < `IQ_ENTRIES; i++) begin
						if (slot_sn[i] > exp_q[idx].sn)
							slot_busy[i] = 1'b0;
					end
				end
				exp_q.delete(idx);
			end
			retire_total++;
		end
		// a write on this edge lands after any flush
		if (claim_pend) begin
			slot_busy[claim_qid] = 1'b1;
			slot_sn[claim_qid]   = claim_sn;
			claim_pend           = 1'b0;
		end
	end

	// ==============================
	// checks
	// ==============================

	// retired sn must be pending, and the oldest one when order matters
	a_retire_sn: assert property (@(negedge clk) disable iff (rst)
		retire_pulse |-> sn_expected(retire_sn))
		else begin
			$display("error %s: retire_sn expected %0d actual %0d", test_name, oldest_sn(),
				retire_sn);
			errors++;
		end

	a_retire_taken: assert property (@(negedge clk) disable iff (rst)
		retire_pulse && find_idx(retire_sn) >= 0 |-> retire_taken == exp_taken(retire_sn))
		else begin
			$display("error %s: retire_taken expected %0b actual %0b", test_name,
				exp_taken(retire_sn), retire_taken);
			errors++;
		end

	a_retire_qid: assert property (@(negedge clk) disable iff (rst)
		retire_pulse && find_idx(retire_sn) >= 0 |-> retire_qid == exp_qid(retire_sn))
		else begin
			$display("error %s: retire_qid expected %0d actual %0d", test_name,
				exp_qid(retire_sn), retire_qid);
			errors++;
		end

	// redirect only rides on a mispredicted retire
	a_redirect: assert property (@(negedge clk) disable iff (rst)
		redirect_valid == (retire_pulse && exp_miss(retire_sn)))
		else begin
			$display("error %s: redirect_valid expected %0b actual %0b", test_name,
				retire_pulse && exp_miss(retire_sn), redirect_valid);
			errors++;
		end

	a_redirect_pc: assert property (@(negedge clk) disable iff (rst)
		redirect_valid && exp_miss(retire_sn) |-> redirect_pc == exp_next_pc(retire_sn))
		else begin
			$display("error %s: redirect_pc expected %h actual %h", test_name,
				exp_next_pc(retire_sn), redirect_pc);
			errors++;
		end

	// counter already holds this retire's miss
	a_miss_count: assert property (@(negedge clk) disable iff (rst)
		retire_pulse |-> int'(miss_count) == exp_misses + int'(exp_miss(retire_sn)))
		else begin
			$display("error %s: miss_count expected %0d actual %0d", test_name,
				exp_misses + int'(exp_miss(retire_sn)), miss_count);
			errors++;
		end

	a_retire_bound: assert property (@(negedge clk) disable iff (rst)
		retire_pulse |-> retire_total < disp_total)
		else begin
			$display("error %s: retire count expected below %0d actual %0d", test_name,
				disp_total, retire_total + 1);
			errors++;
		end

	a_reset_state: assert property (@(negedge clk)
		reset_chk |-> !retire_pulse && !redirect_valid && disp_ready)
		else begin
			$display("error %s: retire/redirect/ready expected 001 actual %b%b%b", test_name,
				retire_pulse, redirect_valid, disp_ready);
			errors++;
		end

	// ==============================
	// stimulus
	// ==============================

	// drives one op, holds it while the queue is full, returns on the write edge
	task automatic send(input fcu_op_e op, input logic [`DATA_W-1:0] a,
			input logic [`DATA_W-1:0] b, input logic [`DATA_W-1:0] pc,
			input logic [`DATA_W-1:0] target, input logic pred, input logic sync,
			input logic keep);
		exp_rec_t rec;
		rec.sn      = sn_ctr;
		rec.taken   = ref_taken(op, a, b);
		rec.miss    = rec.taken != pred;
		rec.next_pc = rec.taken ? target : pc + 32'd4;
		@(negedge clk);
		disp_valid  = 1'b1;
		disp_op     = op;
		disp_a      = a;
		disp_b      = b;
		disp_pc     = pc;
		disp_target = target;
		disp_pred   = pred;
		disp_sync   = sync;
		while (!disp_ready)
			@(negedge clk);
		rec.qid    = lowest_free_slot();
		claim_qid  = rec.qid;
		claim_sn   = rec.sn;
		claim_pend = 1'b1;
		@(posedge clk);
		// flushed ops still consume a sequence number
		if (keep)
			exp_q.push_back(rec);
		sn_ctr = sn_ctr + 1'b1;
		disp_total++;
	endtask

	task automatic send_random(input logic mispredict, input logic sync, input logic keep);
		fcu_op_e            op;
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic [`DATA_W-1:0] pc;
		logic [`DATA_W-1:0] target;
		op     = fcu_op_e'(2'($random(seed)));
		a      = $random(seed);
		b      = $random(seed);
		// equal operands now and then so BEQ and BNE both go either way
		if (2'($random(seed)) == 2'd0)
			b = a;
		pc     = $random(seed) & 32'hffff_fffc;
		target = $random(seed) & 32'hffff_fffc;
		send(op, a, b, pc, target, ref_taken(op, a, b) ^ mispredict, sync, keep);
	endtask

	task automatic release_bus();
		@(negedge clk);
		disp_valid = 1'b0;
		disp_sync  = 1'b0;
	endtask

	// waits on retires until only left ops are still pending
	task automatic wait_pending(input int left, input int limit);
		for (int i = 0; i < limit && exp_q.size() > left; i++)
			@(posedge clk);
		if (exp_q.size() > left) begin
			$display("error %s: %0d ops never retired", test_name, exp_q.size() - left);
			errors++;
		end
	endtask

	// waits on retires until the model is empty
	task automatic wait_drain(input int limit);
		wait_pending(0, limit);
		repeat (4) @(posedge clk);
	endtask

	task automatic test_begin(input string name);
		test_name = name;
		err_mark  = errors;
	endtask

	task automatic test_end();
		tests_run++;
		if (errors != err_mark)
			tests_failed++;
		$display("test %-14s %s", test_name, (errors == err_mark) ? "ok" : "failed");
	endtask

	initial begin
		rst         = 1'b1;
		ce          = 1'b1;
		disp_valid  = 1'b0;
		disp_op     = OP_BEQ;
		disp_a      = '0;
		disp_b      = '0;
		disp_pc     = '0;
		disp_target = '0;
		disp_pred   = 1'b0;
		disp_sync   = 1'b0;

		test_begin("reset_state");
		repeat (16) @(negedge clk);
		rst = 1'b0;
		repeat (2) @(posedge clk);
		reset_chk = 1'b0;
		test_end();

		// one op at a time, always predicted right
		test_begin("condition");
		for (int i = 0; i < N_RAND; i++) begin
			send_random(1'b0, 1'b0, 1'b1);
			release_bus();
			wait_drain(40);
		end
		test_end();

		test_begin("mispredict");
		for (int i = 0; i < 2; i++) begin
			send_random(1'b1, 1'b0, 1'b1);
			release_bus();
			wait_drain(40);
		end
		test_end();

		// younger ops back to back behind a miss, none of them may retire
		test_begin("flush");
		send_random(1'b1, 1'b0, 1'b1);
		for (int i = 0; i < 3; i++)
			send_random(1'b0, 1'b0, 1'b0);
		release_bus();
		wait_drain(80);
		send_random(1'b0, 1'b0, 1'b1);
		release_bus();
		wait_drain(40);
		test_end();

		// the sync op sits in slot 1, younger ops then refill slot 0 below it
		test_begin("sync_order");
		@(negedge clk);
		ce       = 1'b0;
		in_order = 1'b1;
		send_random(1'b0, 1'b0, 1'b1);
		send_random(1'b0, 1'b1, 1'b1);
		release_bus();
		// one cycle of ce lets only the op in slot 0 go
		ce = 1'b1;
		@(negedge clk);
		ce = 1'b0;
		wait_pending(1, 40);
		for (int i = 0; i < 2; i++)
			send_random(1'b0, 1'b0, 1'b1);
		release_bus();
		ce = 1'b1;
		wait_drain(160);
		in_order = 1'b0;
		test_end();

		// eight writes fill the queue, a ninth waits for a free slot
		test_begin("back_pressure");
		@(negedge clk);
		ce = 1'b0;
		for (int i = 0; i < `IQ_ENTRIES; i++)
			send_random(1'b0, 1'b0, 1'b1);
		release_bus();
		a_full: assert (!disp_ready)
			else begin
				$display("error %s: disp_ready expected 0 actual %0b", test_name, disp_ready);
				errors++;
			end
		ce = 1'b1;
		send_random(1'b0, 1'b0, 1'b1);
		release_bus();
		wait_drain(360);
		test_end();

		$display("tests %0d, passed %0d, failed %0d, check errors %0d", tests_run,
			tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// budget of 40 cycles per dispatch plus reset
	initial begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("timeout: run exceeded %0d cycles in test %s", WATCHDOG_CYC, test_name);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
